// File: issue_stage.f
+incdir+tests
design/issue_pkg.sv
design/issue_queue.sv
design/issue_regfile.sv
design/issue_exe_reg.sv
design/issue_top.sv
tests/issue_tb.sv

// File: tests/issue_model.svh
////////////////////
// Reference model

issue_inst_t model_q [$];            // Oldest entry first
xlen_t       model_regs [NREGS];     // Entry 0 is never written
exe_lane_t   exp_lane_a;
exe_lane_t   exp_lane_b;
logic        exp_mul_en;
logic        exp_div_en;

// A disabled lane is expected all zero in its masked fields
function automatic exe_lane_t expect_lane(input issue_inst_t src);
    if (!src.valid) begin
        return '0;
    end
    return {1'b1, src.pc, src.pc_pre, (src.pc_pre != src.pc + 32'd4),
            src.rf_raddr1, src.rf_raddr2,
            model_regs[src.rf_raddr1], model_regs[src.rf_raddr2],
            src.imm, src.alu_op, src.br_type, src.rf_we, src.rf_rd,
            src.mem_we, src.mem_type};
endfunction

task automatic model_step(input logic do_flush, input logic do_stall,
                          input issue_inst_t p1, input issue_inst_t p2,
                          input wb_port_t wa, input wb_port_t wb);
    issue_inst_t older;
    issue_inst_t younger;
    int          n_head;
    n_head  = do_flush ? 0 : ((model_q.size() > 2) ? 2 : model_q.size());
    older   = (n_head > 0) ? model_q[0] : '0;
    younger = (n_head > 1) ? model_q[1] : '0;
    if (!do_stall) begin
        if (older.valid && (older.inst_class != CLS_ALU)) begin
            exp_lane_a = expect_lane(younger);    // Swapped pair
            exp_lane_b = expect_lane(older);
            exp_mul_en = (older.inst_class == CLS_MUL);
            exp_div_en = (older.inst_class == CLS_DIV);
        end else begin
            exp_lane_a = expect_lane(older);
            exp_lane_b = expect_lane(younger);
            exp_mul_en = younger.valid && (younger.inst_class == CLS_MUL);
            exp_div_en = younger.valid && (younger.inst_class == CLS_DIV);
        end
        repeat (n_head) begin
            model_q.delete(0);
        end
    end
    if (do_flush) begin
        model_q.delete();
    end else begin
        if (p1.valid) begin
            model_q.push_back(p1);
        end
        if (p2.valid) begin
            model_q.push_back(p2);
        end
    end
    if (wa.we && (wa.waddr != '0)) begin
        model_regs[wa.waddr] = wa.wdata;
    end
    if (wb.we && (wb.waddr != '0)) begin
        model_regs[wb.waddr] = wb.wdata;                 // B lands last
    end
endtask

task automatic check_lane(input exe_lane_t exp, input exe_lane_t act, input string name);
    logic bad;
    bad = exp.enable ? (act !== exp)
                     : ({act.enable, act.br_type, act.rf_we, act.mem_we, act.mem_type} !== '0);
    if (bad) begin
        $display("** Error: %s expected %h actual %h", name, exp, act);
        raise_failure();
    end
endtask

task automatic check_bit(input logic exp, input logic act, input string name);
    if (act !== exp) begin
        $display("** Error: %s expected %h actual %h", name, exp, act);
        raise_failure();
    end
endtask

// File: tests/issue_tb.sv
`timescale 1ns/1ps

module issue_tb;
    import issue_pkg::*;

    localparam int DEPTH          = 8;
    localparam int PHASE_LEN      = 300;
    localparam int N_PHASES       = 4;
    localparam int TIMEOUT_CYCLES = 2 * N_PHASES * PHASE_LEN;

    logic        clk;
    logic        rstn;
    logic        i_flush;
    logic        i_stall_dcache;
    logic        i_stall_div;
    issue_inst_t i_push1;
    issue_inst_t i_push2;
    wb_port_t    i_wb_a;
    wb_port_t    i_wb_b;
    logic        o_ready;
    exe_lane_t   o_lane_a;
    exe_lane_t   o_lane_b;
    logic        o_mul_en;
    logic        o_div_en;
    logic [31:0] rand_state;
    int          cycle_cnt;

    issue_top #(.ISSUE_DEPTH(DEPTH)) dut_i (.*);

    `include "issue_model.svh"

    task automatic raise_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 8;                           // Drop weak low bits
    endfunction

    function automatic issue_inst_t rand_inst(input bit mixed);
        logic [159:0] raw;
        issue_inst_t  inst;
        raw  = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
        inst = raw[$bits(issue_inst_t)-1:0];
        inst.valid      = 1'b1;
        inst.inst_class = mixed ? inst_class_t'(next_rand() % 5) : CLS_ALU;
        inst.rf_raddr1  = reg_addr_t'(next_rand() % 8);   // Small set that hits write-backs
        inst.rf_raddr2  = reg_addr_t'(next_rand() % 8);
        inst.rf_rd      = reg_addr_t'(next_rand() % 8);
        if ((next_rand() % 2) == 0) begin
            inst.pc_pre = inst.pc + 32'd4;                // Fall-through
        end
        return inst;
    endfunction

    function automatic wb_port_t rand_wb();
        wb_port_t wb;
        wb.we    = (next_rand() % 3) != 0;
        wb.waddr = reg_addr_t'(next_rand() % 8);
        wb.wdata = next_rand();
        return wb;
    endfunction

    task automatic compare_outputs();
        logic room;
        room = (DEPTH - model_q.size()) >= 2;
        check_lane(exp_lane_a, o_lane_a, "o_lane_a");
        check_lane(exp_lane_b, o_lane_b, "o_lane_b");
        check_bit(exp_mul_en, o_mul_en, "o_mul_en");
        check_bit(exp_div_en, o_div_en, "o_div_en");
        check_bit(room, o_ready, "o_ready");
    endtask

    // One cycle per pass from falling edge to falling edge
    task automatic run_phase(input int n_cycles, input bit mixed, input int stall_pct,
                             input int flush_pct);
        logic room;
        repeat (n_cycles) begin
            room = (DEPTH - model_q.size()) >= 2;
            compare_outputs();
            i_stall_dcache = (next_rand() % 100) < stall_pct;
            i_stall_div    = (next_rand() % 100) < (stall_pct / 2);
            i_flush        = (next_rand() % 100) < flush_pct;
            i_push1        = rand_inst(mixed);
            i_push2        = rand_inst(mixed);
            i_push1.valid  = room && ((next_rand() % 4) != 0);
            i_push2.valid  = room && ((next_rand() % 4) != 0);
            i_wb_a         = rand_wb();
            i_wb_b         = rand_wb();
            if ((next_rand() % 4) == 0) begin
                i_wb_b.waddr = i_wb_a.waddr;              // Write collision
            end
            model_step(i_flush, i_stall_dcache | i_stall_div, i_push1, i_push2, i_wb_a, i_wb_b);
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
            raise_failure();
        end
    end

    initial begin
        rand_state     = 32'hbd94;
        cycle_cnt      = 0;
        rstn           = 1'b0;
        i_flush        = 1'b0;
        i_stall_dcache = 1'b0;
        i_stall_div    = 1'b0;
        i_push1        = '0;
        i_push2        = '0;
        i_wb_a         = '0;
        i_wb_b         = '0;
        exp_lane_a     = '0;
        exp_lane_b     = '0;
        exp_mul_en     = 1'b0;
        exp_div_en     = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        run_phase(PHASE_LEN, 1'b0, 0, 0);     // ALU pairs
        run_phase(PHASE_LEN, 1'b1, 0, 0);     // Swaps with mul and div enables
        run_phase(PHASE_LEN, 1'b1, 50, 0);    // Stalls fill the queue
        run_phase(PHASE_LEN, 1'b1, 20, 10);   // Flushes
        compare_outputs();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: design/issue_top.sv
`timescale 1ns/1ps

module issue_top #(
    parameter int ISSUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  logic                   i_stall_dcache,
    input  logic                   i_stall_div,
    input  issue_pkg::issue_inst_t i_push1,
    input  issue_pkg::issue_inst_t i_push2,
    input  issue_pkg::wb_port_t    i_wb_a,
    input  issue_pkg::wb_port_t    i_wb_b,
    output logic                   o_ready,
    output issue_pkg::exe_lane_t   o_lane_a,
    output issue_pkg::exe_lane_t   o_lane_b,
    output logic                   o_mul_en,
    output logic                   o_div_en
);
    import issue_pkg::*;

    issue_inst_t set1;
    issue_inst_t set2;
    logic        take;
    xlen_t       rdata_a1;
    xlen_t       rdata_a2;
    xlen_t       rdata_b1;
    xlen_t       rdata_b2;

    issue_queue #(
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) queue_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_flush (i_flush),
        .i_take  (take),
        .i_push1 (i_push1),
        .i_push2 (i_push2),
        .o_set1  (set1),
        .o_set2  (set2),
        .o_ready (o_ready)
    );

    issue_regfile regfile_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_raddr_a1 (set1.rf_raddr1),
        .i_raddr_a2 (set1.rf_raddr2),
        .i_raddr_b1 (set2.rf_raddr1),
        .i_raddr_b2 (set2.rf_raddr2),
        .o_rdata_a1 (rdata_a1),
        .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1),
        .o_rdata_b2 (rdata_b2),
        .i_wb_a     (i_wb_a),
        .i_wb_b     (i_wb_b)
    );

    issue_exe_reg exe_reg_i (
        .clk            (clk),
        .rstn           (rstn),
        .i_stall_dcache (i_stall_dcache),
        .i_stall_div    (i_stall_div),
        .i_set1         (set1),
        .i_set2         (set2),
        .i_rdata_a1     (rdata_a1),
        .i_rdata_a2     (rdata_a2),
        .i_rdata_b1     (rdata_b1),
        .i_rdata_b2     (rdata_b2),
        .o_take         (take),
        .o_lane_a       (o_lane_a),
        .o_lane_b       (o_lane_b),
        .o_mul_en       (o_mul_en),
        .o_div_en       (o_div_en)
    );

endmodule

// File: design/issue_exe_reg.sv
`timescale 1ns/1ps

module issue_exe_reg (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_stall_dcache,
    input  logic                   i_stall_div,
    input  issue_pkg::issue_inst_t i_set1,
    input  issue_pkg::issue_inst_t i_set2,
    input  issue_pkg::xlen_t       i_rdata_a1,
    input  issue_pkg::xlen_t       i_rdata_a2,
    input  issue_pkg::xlen_t       i_rdata_b1,
    input  issue_pkg::xlen_t       i_rdata_b2,
    output logic                   o_take,
    output issue_pkg::exe_lane_t   o_lane_a,
    output issue_pkg::exe_lane_t   o_lane_b,
    output logic                   o_mul_en,
    output logic                   o_div_en
);
    import issue_pkg::*;

    logic        stall;
    logic        swap;

    issue_inst_t src_a;
    issue_inst_t src_b;
    xlen_t       lane_a_rdata1;
    xlen_t       lane_a_rdata2;
    xlen_t       lane_b_rdata1;
    xlen_t       lane_b_rdata2;

    exe_lane_t   lane_a_nxt;
    exe_lane_t   lane_b_nxt;
    logic        mul_en_nxt;
    logic        div_en_nxt;

    // Assemble one lane; side-effect fields are masked by valid
    function automatic exe_lane_t build_lane(issue_inst_t src, xlen_t rdata1, xlen_t rdata2);
        exe_lane_t lane;
        lane.enable    = src.valid;
        lane.pc        = src.pc;
        lane.pc_pre    = src.pc_pre;
        lane.br_pd     = (src.pc_pre != src.pc + xlen_t'(4));
        lane.rf_raddr1 = src.rf_raddr1;
        lane.rf_raddr2 = src.rf_raddr2;
        lane.rf_rdata1 = rdata1;
        lane.rf_rdata2 = rdata2;
        lane.imm       = src.imm;
        lane.alu_op    = src.alu_op;
        lane.br_type   = src.valid ? src.br_type : '0;
        lane.rf_we     = src.valid & src.rf_we;
        lane.rf_waddr  = src.rf_rd;
        lane.mem_we    = src.valid & src.mem_we;
        lane.mem_type  = src.valid ? src.mem_type : '0;
        return lane;
    endfunction

    ////////////////////
    // Stall and steering

    assign stall  = i_stall_dcache | i_stall_div;
    assign o_take = ~stall;                           // Queue head holds while stalled

    // Older non-ALU instruction moves to lane B
    assign swap = (i_set1.inst_class != CLS_ALU);

    assign src_a = swap ? i_set2 : i_set1;
    assign src_b = swap ? i_set1 : i_set2;

    assign lane_a_rdata1 = swap ? i_rdata_b1 : i_rdata_a1;
    assign lane_a_rdata2 = swap ? i_rdata_b2 : i_rdata_a2;
    assign lane_b_rdata1 = swap ? i_rdata_a1 : i_rdata_b1;
    assign lane_b_rdata2 = swap ? i_rdata_a2 : i_rdata_b2;

    assign lane_a_nxt = build_lane(src_a, lane_a_rdata1, lane_a_rdata2);
    assign lane_b_nxt = build_lane(src_b, lane_b_rdata1, lane_b_rdata2);

    assign mul_en_nxt = src_b.valid & (src_b.inst_class == CLS_MUL);
    assign div_en_nxt = src_b.valid & (src_b.inst_class == CLS_DIV);

    ////////////////////
    // Issue to execute register

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_lane_a <= '0;
            o_lane_b <= '0;
            o_mul_en <= 1'b0;
            o_div_en <= 1'b0;
        end else if (!stall) begin
            o_lane_a <= lane_a_nxt;
            o_lane_b <= lane_b_nxt;
            o_mul_en <= mul_en_nxt;
            o_div_en <= div_en_nxt;
        end
    end

endmodule

// File: design/issue_regfile.sv
`timescale 1ns/1ps

module issue_regfile (
    input  logic                 clk,
    input  logic                 rstn,
    input  issue_pkg::reg_addr_t i_raddr_a1,
    input  issue_pkg::reg_addr_t i_raddr_a2,
    input  issue_pkg::reg_addr_t i_raddr_b1,
    input  issue_pkg::reg_addr_t i_raddr_b2,
    output issue_pkg::xlen_t     o_rdata_a1,
    output issue_pkg::xlen_t     o_rdata_a2,
    output issue_pkg::xlen_t     o_rdata_b1,
    output issue_pkg::xlen_t     o_rdata_b2,
    input  issue_pkg::wb_port_t  i_wb_a,
    input  issue_pkg::wb_port_t  i_wb_b
);
    import issue_pkg::*;

    xlen_t regs [NREGS];

    ////////////////////
    // Read ports

    assign o_rdata_a1 = (i_raddr_a1 == '0) ? '0 : regs[i_raddr_a1];
    assign o_rdata_a2 = (i_raddr_a2 == '0) ? '0 : regs[i_raddr_a2];
    assign o_rdata_b1 = (i_raddr_b1 == '0) ? '0 : regs[i_raddr_b1];
    assign o_rdata_b2 = (i_raddr_b2 == '0) ? '0 : regs[i_raddr_b2];

    ////////////////////
    // Write ports

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wb_a.we && (i_wb_a.waddr != '0)) begin
                regs[i_wb_a.waddr] <= i_wb_a.wdata;
            end
            // Assigned last so port B wins a collision
            if (i_wb_b.we && (i_wb_b.waddr != '0)) begin
                regs[i_wb_b.waddr] <= i_wb_b.wdata;
            end
        end
    end

endmodule

// File: design/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
    parameter int ISSUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  logic                   i_take,
    input  issue_pkg::issue_inst_t i_push1,
    input  issue_pkg::issue_inst_t i_push2,
    output issue_pkg::issue_inst_t o_set1,
    output issue_pkg::issue_inst_t o_set2,
    output logic                   o_ready
);
    import issue_pkg::*;

    localparam int PTR_W = $clog2(ISSUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    issue_inst_t ring [ISSUE_DEPTH];

    ptr_t head;
    ptr_t tail;
    cnt_t count;

    cnt_t n_push;
    cnt_t n_pop;
    cnt_t free_slots;
    ptr_t wr_ptr2;

    ////////////////////
    // Head window

    always_comb begin
        o_set1       = ring[head];
        o_set1.valid = (count != '0) & ~i_flush;
        o_set2       = ring[head + ptr_t'(1)];
        o_set2.valid = (count > cnt_t'(1)) & ~i_flush;
    end

    assign free_slots = cnt_t'(ISSUE_DEPTH) - count;
    assign o_ready    = (free_slots >= cnt_t'(2));    // Room for a full pair

    ////////////////////
    // Push and pop

    assign n_push  = cnt_t'(i_push1.valid) + cnt_t'(i_push2.valid);
    assign n_pop   = i_take ? cnt_t'(o_set1.valid) + cnt_t'(o_set2.valid) : '0;
    assign wr_ptr2 = tail + ptr_t'(i_push1.valid);   // Compacts a lone push2

    always_ff @(posedge clk) begin
        if (i_push1.valid) begin
            ring[tail] <= i_push1;
        end
        if (i_push2.valid) begin
            ring[wr_ptr2] <= i_push2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (i_flush) begin
            // Drops waiting entries and this cycle's pushes
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(n_pop);
            tail  <= tail + ptr_t'(n_push);
            count <= count + n_push - n_pop;
        end
    end

endmodule

// File: design/issue_pkg.sv
package issue_pkg;

    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [$clog2(NREGS)-1:0] reg_addr_t;
    typedef logic [11:0]              alu_op_t;      // One-hot
    typedef logic [3:0]               br_type_t;     // Zero when not a branch
    typedef logic [2:0]               mem_type_t;    // Zero when no access

    typedef enum logic [2:0] {
        CLS_ALU = 3'd0,
        CLS_MUL = 3'd1,
        CLS_DIV = 3'd2,
        CLS_BR  = 3'd3,
        CLS_MEM = 3'd4
    } inst_class_t;

    typedef struct packed {
        logic        valid;
        xlen_t       pc;
        xlen_t       pc_pre;       // Predicted next PC
        inst_class_t inst_class;
        reg_addr_t   rf_raddr1;
        reg_addr_t   rf_raddr2;
        reg_addr_t   rf_rd;
        logic        rf_we;
        xlen_t       imm;
        alu_op_t     alu_op;
        br_type_t    br_type;
        logic        mem_we;
        mem_type_t   mem_type;
        logic        sign_bit;     // Signed mul/div
    } issue_inst_t;

    typedef struct packed {
        logic      enable;
        xlen_t     pc;
        xlen_t     pc_pre;
        logic      br_pd;          // Predicted taken
        reg_addr_t rf_raddr1;
        reg_addr_t rf_raddr2;
        xlen_t     rf_rdata1;
        xlen_t     rf_rdata2;
        xlen_t     imm;
        alu_op_t   alu_op;
        br_type_t  br_type;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      mem_we;
        mem_type_t mem_type;
    } exe_lane_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } wb_port_t;

endpackage
